//--- sim.f
design/csr_addr_pkg.sv
design/excp_pkg.sv
design/csr_write_if.sv
design/excp_csr_regs.sv
design/csr_timer.sv
design/csr_unit.sv
testbench/csr_unit_props.sv
testbench/csr_unit_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := csr_unit_tb
LINT_TOP  := csr_unit
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int ONESHOT_N = 8;
    localparam int PERIODIC_N = 3;
    // Sum of the test lengths in cycles plus a margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 72 + 24 + 40
                                     + (4 * ONESHOT_N + 2) + 12
                                     + 2 * (4 * PERIODIC_N + 1) + 12 + 48 + 100;

    logic                      clk;
    logic                      reset;
    logic                      valid;
    logic                      csr_we;
    csr_addr_pkg::csr_num_e    csr_num;
    logic [31:0]               csr_wvalue;
    logic [31:0]               csr_wmask;
    logic                      wb_ex;
    logic                      ertn_flush;
    excp_pkg::ecode_e          wb_ecode;
    logic [8:0]                wb_esubcode;
    logic [31:0]               wb_pc;
    logic [31:0]               wb_vaddr;
    logic [31:0]               csr_rvalue;
    logic [31:0]               ex_entry;
    logic [31:0]               era_pc;
    logic                      has_int;
    logic [31:0]               crmd;

    // Shadow state of the CSRs
    logic [1:0]  plv, pplv, swi;
    logic        ie, da, pg, pie, en, per, tint;
    logic [12:0] lie;
    logic [5:0]  ecode;
    logic [8:0]  esub;
    logic [31:0] era, badv, tid, cnt;
    logic [25:0] eentry_va;
    logic [29:0] initval;
    logic [31:0] save [4];

    integer seed = 32'h1848;
    int errors = 0;
    int checks = 0;
    int test_no = 0;
    int err_mark = 0;

    csr_addr_pkg::csr_num_e targets[12] = '{
        csr_addr_pkg::SAVE0, csr_addr_pkg::SAVE1, csr_addr_pkg::SAVE2, csr_addr_pkg::SAVE3,
        csr_addr_pkg::ERA, csr_addr_pkg::EENTRY, csr_addr_pkg::PRMD, csr_addr_pkg::ECFG,
        csr_addr_pkg::BADV, csr_addr_pkg::CRMD, csr_addr_pkg::TID, csr_addr_pkg::TCFG};
    excp_pkg::ecode_e codes[12] = '{
        excp_pkg::INT, excp_pkg::PIL, excp_pkg::PIS, excp_pkg::PIF, excp_pkg::PME,
        excp_pkg::PPI, excp_pkg::ADE, excp_pkg::ALE, excp_pkg::SYS, excp_pkg::BRK,
        excp_pkg::INE, excp_pkg::TLBR};

    csr_unit #(.SAVE_COUNT(4)) UUT (
        .clk(clk), .reset(reset), .valid(valid), .csr_we(csr_we), .csr_num(csr_num),
        .csr_wvalue(csr_wvalue), .csr_wmask(csr_wmask), .csr_rvalue(csr_rvalue),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush), .wb_ecode(wb_ecode),
        .wb_esubcode(wb_esubcode), .wb_pc(wb_pc), .wb_vaddr(wb_vaddr),
        .ex_entry(ex_entry), .era_pc(era_pc), .has_int(has_int), .crmd(crmd)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [12:0] model_is();
        logic [12:0] v;
        v = '0;
        v[1:0] = swi;
        v[excp_pkg::TI_BIT] = tint;
        return v;
    endfunction

    function automatic logic model_has_int();
        return (|(model_is() & lie)) && ie;
    endfunction

    function automatic logic [31:0] model_read(input csr_addr_pkg::csr_num_e num);
        logic [31:0] r;
        r = '0;
        case (num)
            csr_addr_pkg::CRMD:   r[4:0] = {pg, da, ie, plv};
            csr_addr_pkg::PRMD:   r[2:0] = {pie, pplv};
            csr_addr_pkg::ECFG:   r[12:0] = lie;
            csr_addr_pkg::ESTAT:  r = {1'b0, esub, ecode, 3'b000, model_is()};
            csr_addr_pkg::ERA:    r = era;
            csr_addr_pkg::BADV:   r = badv;
            csr_addr_pkg::EENTRY: r = {eentry_va, 6'b0};
            csr_addr_pkg::SAVE0, csr_addr_pkg::SAVE1,
            csr_addr_pkg::SAVE2, csr_addr_pkg::SAVE3: r = save[num[1:0]];
            csr_addr_pkg::TID:    r = tid;
            csr_addr_pkg::TCFG:   r = {initval, per, en};
            csr_addr_pkg::TVAL:   r = cnt;
            default:              r = '0;
        endcase
        return r;
    endfunction

    // Unknown expected bits belong to registers not yet written
    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        logic [31:0] known;
        int i;
        for (i = 0; i < 32; i++) known[i] = (exp[i] !== 1'bx);
        checks++;
        assert ((act & known) === (exp & known)) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic step_model();
        logic [31:0] m;
        logic        we_eff, old_ie, old_pie, cnt_zero;
        logic [1:0]  old_plv, old_pplv;
        m = (csr_wmask & csr_wvalue) | (~csr_wmask & model_read(csr_num));
        we_eff = csr_we & valid;
        old_plv = plv;
        old_ie = ie;
        old_pplv = pplv;
        old_pie = pie;
        cnt_zero = (cnt == 32'h0);
        // Timer runs on the configuration from before this edge
        if (we_eff && csr_num == csr_addr_pkg::TCFG && m[0])
            cnt = {m[31:2], 2'b00};
        else if (en && cnt != 32'hFFFF_FFFF)
            cnt = (cnt_zero && per) ? {initval, 2'b00} : cnt - 32'd1;
        if (cnt_zero)
            tint = 1'b1;
        else if (we_eff && csr_num == csr_addr_pkg::TICLR && m[0])
            tint = 1'b0;
        if (we_eff) begin
            case (csr_num)
                csr_addr_pkg::CRMD:   {pg, da, ie, plv} = m[4:0];
                csr_addr_pkg::PRMD:   {pie, pplv} = m[2:0];
                csr_addr_pkg::ECFG:   lie = m[12:0] & excp_pkg::LIE_MASK;
                csr_addr_pkg::ESTAT:  swi = m[1:0];
                csr_addr_pkg::ERA:    era = m;
                csr_addr_pkg::BADV:   badv = m;
                csr_addr_pkg::EENTRY: eentry_va = m[31:6];
                csr_addr_pkg::SAVE0, csr_addr_pkg::SAVE1,
                csr_addr_pkg::SAVE2, csr_addr_pkg::SAVE3: save[csr_num[1:0]] = m;
                csr_addr_pkg::TID:    tid = m;
                csr_addr_pkg::TCFG:   {initval, per, en} = m;
                default: ;
            endcase
        end
        if (ertn_flush) begin
            plv = old_pplv;
            ie = old_pie;
        end
        if (wb_ex) begin
            plv = 2'b00;
            ie = 1'b0;
            pplv = old_plv;
            pie = old_ie;
            era = wb_pc;
            ecode = wb_ecode;
            esub = wb_esubcode;
            if (wb_ecode inside {excp_pkg::ADE, excp_pkg::ALE, excp_pkg::PIL, excp_pkg::PIS,
                                 excp_pkg::PIF, excp_pkg::PPI, excp_pkg::PME, excp_pkg::TLBR})
                badv = (wb_ecode == excp_pkg::ADE && wb_esubcode == 9'd0) ? wb_pc : wb_vaddr;
        end
    endtask

    // Compare first, then advance the shadow state across this edge
    always @(posedge clk) begin
        if (reset) begin
            {plv, ie, da, pg} = {2'b00, 1'b0, 1'b1, 1'b0};
            {lie, swi, tid, en, tint} = '0;
            cnt = 32'hFFFF_FFFF;
        end else begin
            check_word($sformatf("csr_rvalue (csr %0h)", csr_num), model_read(csr_num),
                       csr_rvalue);
            check_word("has_int", {31'b0, model_has_int()}, {31'b0, has_int});
            check_word("ex_entry", {eentry_va, 6'b0}, ex_entry);
            check_word("era_pc", era, era_pc);
            check_word("crmd", model_read(csr_addr_pkg::CRMD), crmd);
            step_model();
        end
    end

    task automatic set_idle();
        valid = 1'b1;
        csr_we = 1'b0;
        wb_ex = 1'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic write_csr(input csr_addr_pkg::csr_num_e num, input logic [31:0] value,
                             input logic [31:0] mask, input logic vld);
        @(negedge clk);
        set_idle();
        valid = vld;
        csr_we = 1'b1;
        csr_num = num;
        csr_wvalue = value;
        csr_wmask = mask;
    endtask

    task automatic read_csr(input csr_addr_pkg::csr_num_e num);
        @(negedge clk);
        set_idle();
        csr_num = num;
    endtask

    task automatic raise_exception(input excp_pkg::ecode_e ec, input logic [8:0] sub);
        @(negedge clk);
        set_idle();
        wb_ex = 1'b1;
        wb_ecode = ec;
        wb_esubcode = sub;
        wb_pc = $random(seed);
        wb_vaddr = $random(seed);
    endtask

    task automatic return_ertn();
        @(negedge clk);
        set_idle();
        ertn_flush = 1'b1;
    endtask

    task automatic finish_test(input string name);
        test_no++;
        $display("Test %0d %s: %0d errors", test_no, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        int edges;
        excp_pkg::ecode_e ec;
        logic [8:0] sub;
        {valid, csr_we, wb_ex, ertn_flush} = '0;
        {csr_wvalue, csr_wmask, wb_esubcode, wb_pc, wb_vaddr} = '0;
        csr_num = csr_addr_pkg::CRMD;
        wb_ecode = excp_pkg::INT;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int r = 0; r < 4; r++) begin
            for (int t = 0; t < 9; t++) begin
                write_csr(targets[t], $random(seed), (r == 0) ? '1 : $random(seed), 1'b1);
                read_csr(targets[t]);
            end
        end
        finish_test("masked read back");

        for (int t = 0; t < 12; t++) write_csr(targets[t], $random(seed), '1, 1'b0);
        for (int t = 0; t < 12; t++) read_csr(targets[t]);
        finish_test("writes without valid");

        for (int k = 0; k < 4; k++) begin
            write_csr(csr_addr_pkg::CRMD, $random(seed), 32'h7, 1'b1);
            ec = codes[$unsigned($random(seed)) % 12];
            sub = (ec == excp_pkg::ADE) ? 9'($unsigned($random(seed)) % 2) : 9'($random(seed));
            raise_exception(ec, sub);
            read_csr(csr_addr_pkg::CRMD);
            read_csr(csr_addr_pkg::PRMD);
            read_csr(csr_addr_pkg::ERA);
            read_csr(csr_addr_pkg::ESTAT);
            read_csr(csr_addr_pkg::BADV);
            return_ertn();
            read_csr(csr_addr_pkg::CRMD);
        end
        finish_test("exception entry and return");

        write_csr(csr_addr_pkg::TCFG, (ONESHOT_N << 2) | 1, '1, 1'b1);
        read_csr(csr_addr_pkg::ESTAT);
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (!csr_rvalue[excp_pkg::TI_BIT] && edges < 4 * ONESHOT_N + 4);
        check_word("timer interrupt edge count", 4 * ONESHOT_N + 1, edges);
        write_csr(csr_addr_pkg::TICLR, 32'h1, 32'h1, 1'b1);
        repeat (3) read_csr(csr_addr_pkg::ESTAT);
        finish_test("one-shot timer");

        write_csr(csr_addr_pkg::TCFG, (PERIODIC_N << 2) | 3, '1, 1'b1);
        repeat (2 * (4 * PERIODIC_N + 1) + 2) read_csr(csr_addr_pkg::TVAL);
        read_csr(csr_addr_pkg::ESTAT);
        write_csr(csr_addr_pkg::TICLR, 32'h1, 32'h1, 1'b1);
        read_csr(csr_addr_pkg::ESTAT);
        write_csr(csr_addr_pkg::TCFG, 32'h0, '1, 1'b1);
        finish_test("periodic timer");

        // Short one-shot run so the timer flag joins the mix
        write_csr(csr_addr_pkg::TCFG, (1 << 2) | 1, '1, 1'b1);
        repeat (6) read_csr(csr_addr_pkg::ESTAT);
        for (int k = 0; k < 8; k++) begin
            write_csr(csr_addr_pkg::ECFG, $random(seed), '1, 1'b1);
            write_csr(csr_addr_pkg::ESTAT, $random(seed), '1, 1'b1);
            write_csr(csr_addr_pkg::CRMD, $random(seed), 32'h4, 1'b1);
            write_csr(csr_addr_pkg::TICLR, $random(seed), 32'h1, 1'b1);
            read_csr(csr_addr_pkg::ESTAT);
        end
        finish_test("interrupt detection");

        @(negedge clk);
        set_idle();
        $display("Tests %0d, checks %0d, errors %0d", test_no, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Timeout: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/csr_unit_props.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_props (
    input wire                               clk,
    input wire                               reset,
    input wire                               wb_ex,
    input wire [csr_addr_pkg::DATA_W-1:0]    wb_pc,
    input wire [csr_addr_pkg::DATA_W-1:0]    era_pc,
    input wire [csr_addr_pkg::DATA_W-1:0]    crmd,
    input wire                               has_int
);

    // IE is cleared by reset, so no interrupt can be pending right after it
    no_int_after_reset: assert property (@(posedge clk) reset |=> !has_int)
        else $error("has_int active after a reset cycle");

    ex_clears_plv: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> crmd[csr_addr_pkg::CRMD_PLV_LO +: csr_addr_pkg::CRMD_PLV_W] == '0)
        else $error("CRMD PLV not zero after exception entry");

    ex_saves_pc: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> era_pc == $past(wb_pc))
        else $error("era_pc does not hold the excepting pc");

endmodule

bind csr_unit csr_unit_props u_props (
    .clk     (clk),
    .reset   (reset),
    .wb_ex   (wb_ex),
    .wb_pc   (wb_pc),
    .era_pc  (era_pc),
    .crmd    (crmd),
    .has_int (has_int)
);

`default_nettype wire

//--- design/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                                 clk,
    input  wire                                 reset,

    // Instruction side
    input  wire                                 valid,
    input  wire                                 csr_we,
    input  wire csr_addr_pkg::csr_num_e         csr_num,
    input  wire [csr_addr_pkg::DATA_W-1:0]      csr_wvalue,
    input  wire [csr_addr_pkg::DATA_W-1:0]      csr_wmask,
    output logic [csr_addr_pkg::DATA_W-1:0]     csr_rvalue,

    // Writeback stage exception and return
    input  wire                                 wb_ex,
    input  wire                                 ertn_flush,
    input  wire excp_pkg::ecode_e               wb_ecode,
    input  wire [excp_pkg::ESUBCODE_W-1:0]      wb_esubcode,
    input  wire [csr_addr_pkg::DATA_W-1:0]      wb_pc,
    input  wire [csr_addr_pkg::DATA_W-1:0]      wb_vaddr,

    output logic [csr_addr_pkg::DATA_W-1:0]     ex_entry,
    output logic [csr_addr_pkg::DATA_W-1:0]     era_pc,
    output logic                                has_int,
    output logic [csr_addr_pkg::DATA_W-1:0]     crmd
);

    logic [csr_addr_pkg::DATA_W-1:0]    regs_rdata;
    logic [csr_addr_pkg::DATA_W-1:0]    timer_rdata;
    logic                               timer_int;

    csr_write_if wr_bus ();

    // Only a valid instruction may write
    assign wr_bus.we = csr_we & valid;
    assign wr_bus.num = csr_num;
    assign wr_bus.wvalue = csr_wvalue;
    assign wr_bus.wmask = csr_wmask;

    excp_csr_regs #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_excp_regs (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr_bus),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .timer_int   (timer_int),
        .rdata       (regs_rdata),
        .ex_entry    (ex_entry),
        .era_pc      (era_pc),
        .has_int     (has_int),
        .crmd        (crmd)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr_bus),
        .rdata     (timer_rdata),
        .timer_int (timer_int)
    );

    // Each block returns zero for numbers it does not own
    assign csr_rvalue = regs_rdata | timer_rdata;

endmodule

`default_nettype wire

//--- design/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  wire                                 clk,
    input  wire                                 reset,
    csr_write_if.consumer                       wr,
    output logic [csr_addr_pkg::DATA_W-1:0]     rdata,
    output logic                                timer_int
);

    logic [csr_addr_pkg::DATA_W-1:0]            tid_q;
    logic                                       en_q;
    logic                                       periodic_q;
    logic [csr_addr_pkg::TCFG_INITVAL_W-1:0]    initval_q;
    logic [csr_addr_pkg::DATA_W-1:0]            cnt_q;
    logic [csr_addr_pkg::DATA_W-1:0]            tcfg_word;
    logic [csr_addr_pkg::DATA_W-1:0]            merged;
    logic                                       wr_tcfg;
    logic                                       ticlr_hit;

    assign merged = (wr.wmask & wr.wvalue) | (~wr.wmask & rdata);
    assign wr_tcfg = wr.we && wr.num == csr_addr_pkg::TCFG;
    // TICLR reads zero, so merged CLR is the masked write bit
    assign ticlr_hit = wr.we && wr.num == csr_addr_pkg::TICLR
                       && merged[csr_addr_pkg::TICLR_CLR_LO];

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_q <= '0;
        end else if (wr.we && wr.num == csr_addr_pkg::TID) begin
            tid_q <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            en_q <= 1'b0;
        end else if (wr_tcfg) begin
            en_q <= merged[csr_addr_pkg::TCFG_EN_LO];
        end
        if (wr_tcfg) begin
            periodic_q <= merged[csr_addr_pkg::TCFG_PERIODIC_LO];
            initval_q <= merged[csr_addr_pkg::TCFG_INITVAL_LO +: csr_addr_pkg::TCFG_INITVAL_W];
        end
    end

    // Countdown parks at all ones when a one-shot run expires
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q <= '1;
        end else if (wr_tcfg && merged[csr_addr_pkg::TCFG_EN_LO]) begin
            cnt_q <= {merged[csr_addr_pkg::TCFG_INITVAL_LO +: csr_addr_pkg::TCFG_INITVAL_W],
                      2'b00};
        end else if (en_q && cnt_q != '1) begin
            if (cnt_q == '0 && periodic_q) begin
                cnt_q <= {initval_q, 2'b00};
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (cnt_q == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr_hit) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        tcfg_word = '0;
        tcfg_word[csr_addr_pkg::TCFG_EN_LO] = en_q;
        tcfg_word[csr_addr_pkg::TCFG_PERIODIC_LO] = periodic_q;
        tcfg_word[csr_addr_pkg::TCFG_INITVAL_LO +: csr_addr_pkg::TCFG_INITVAL_W] = initval_q;
    end

    always_comb begin
        case (wr.num)
            csr_addr_pkg::TID:  rdata = tid_q;
            csr_addr_pkg::TCFG: rdata = tcfg_word;
            csr_addr_pkg::TVAL: rdata = cnt_q;
            default:            rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/excp_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module excp_csr_regs #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                                 clk,
    input  wire                                 reset,
    csr_write_if.consumer                       wr,
    input  wire                                 wb_ex,
    input  wire                                 ertn_flush,
    input  wire excp_pkg::ecode_e               wb_ecode,
    input  wire [excp_pkg::ESUBCODE_W-1:0]      wb_esubcode,
    input  wire [csr_addr_pkg::DATA_W-1:0]      wb_pc,
    input  wire [csr_addr_pkg::DATA_W-1:0]      wb_vaddr,
    input  wire                                 timer_int,
    output logic [csr_addr_pkg::DATA_W-1:0]     rdata,
    output logic [csr_addr_pkg::DATA_W-1:0]     ex_entry,
    output logic [csr_addr_pkg::DATA_W-1:0]     era_pc,
    output logic                                has_int,
    output logic [csr_addr_pkg::DATA_W-1:0]     crmd
);

    localparam int SAVE_IDX_W = (SAVE_COUNT > 1) ? $clog2(SAVE_COUNT) : 1;
    localparam logic [csr_addr_pkg::CSR_NUM_W-1:0] SAVE_LIMIT =
        csr_addr_pkg::CSR_NUM_W'(SAVE_COUNT);

    logic [csr_addr_pkg::CRMD_PLV_W-1:0]        plv_q;
    logic                                       ie_q;
    logic                                       da_q;
    logic                                       pg_q;
    logic [csr_addr_pkg::PRMD_PPLV_W-1:0]       pplv_q;
    logic                                       pie_q;
    logic [excp_pkg::IS_W-1:0]                  lie_q;
    logic [excp_pkg::SWI_W-1:0]                 swi_q;
    logic [csr_addr_pkg::ESTAT_ECODE_W-1:0]     ecode_q;
    logic [csr_addr_pkg::ESTAT_ESUBCODE_W-1:0]  esubcode_q;
    logic [csr_addr_pkg::DATA_W-1:0]            era_q;
    logic [csr_addr_pkg::EENTRY_VA_W-1:0]       eentry_va_q;
    logic [csr_addr_pkg::DATA_W-1:0]            badv_q;
    logic [csr_addr_pkg::DATA_W-1:0]            save_q [SAVE_COUNT];

    logic [excp_pkg::IS_W-1:0]                  is_vec;
    logic [csr_addr_pkg::DATA_W-1:0]            estat_word;
    logic [csr_addr_pkg::DATA_W-1:0]            prmd_word;
    logic [csr_addr_pkg::DATA_W-1:0]            merged;
    logic [csr_addr_pkg::CSR_NUM_W-1:0]         save_off;
    logic [SAVE_IDX_W-1:0]                      save_idx;
    logic                                       save_hit;
    logic                                       addr_err;

    // New value of the addressed register under the write mask
    assign merged = (wr.wmask & wr.wvalue) | (~wr.wmask & rdata);

    assign save_off = wr.num - csr_addr_pkg::SAVE0;
    assign save_hit = save_off < SAVE_LIMIT;
    assign save_idx = save_off[SAVE_IDX_W-1:0];

    assign addr_err = wb_ecode inside {excp_pkg::ADE, excp_pkg::ALE, excp_pkg::PIL,
                                       excp_pkg::PIS, excp_pkg::PIF, excp_pkg::PPI,
                                       excp_pkg::PME, excp_pkg::TLBR};

    always_ff @(posedge clk) begin
        if (reset) begin
            plv_q <= '0;
            ie_q <= 1'b0;
        end else if (wb_ex) begin
            plv_q <= '0;
            ie_q <= 1'b0;
        end else if (ertn_flush) begin
            plv_q <= pplv_q;
            ie_q <= pie_q;
        end else if (wr.we && wr.num == csr_addr_pkg::CRMD) begin
            plv_q <= merged[csr_addr_pkg::CRMD_PLV_LO +: csr_addr_pkg::CRMD_PLV_W];
            ie_q <= merged[csr_addr_pkg::CRMD_IE_LO];
        end
    end

    // DA and PG only move by software
    always_ff @(posedge clk) begin
        if (reset) begin
            da_q <= 1'b1;
            pg_q <= 1'b0;
        end else if (wr.we && wr.num == csr_addr_pkg::CRMD) begin
            da_q <= merged[csr_addr_pkg::CRMD_DA_LO];
            pg_q <= merged[csr_addr_pkg::CRMD_PG_LO];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            pplv_q <= plv_q;
            pie_q <= ie_q;
            era_q <= wb_pc;
        end else if (wr.we && wr.num == csr_addr_pkg::PRMD) begin
            pplv_q <= merged[csr_addr_pkg::PRMD_PPLV_LO +: csr_addr_pkg::PRMD_PPLV_W];
            pie_q <= merged[csr_addr_pkg::PRMD_PIE_LO];
        end else if (wr.we && wr.num == csr_addr_pkg::ERA) begin
            era_q <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lie_q <= '0;
            swi_q <= '0;
        end else if (wr.we && wr.num == csr_addr_pkg::ECFG) begin
            lie_q <= merged[excp_pkg::IS_W-1:0] & excp_pkg::LIE_MASK;
        end else if (wr.we && wr.num == csr_addr_pkg::ESTAT) begin
            swi_q <= merged[csr_addr_pkg::ESTAT_IS_LO +: excp_pkg::SWI_W];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            ecode_q <= wb_ecode;
            esubcode_q <= wb_esubcode;
        end
        if (wb_ex && addr_err) begin
            badv_q <= (wb_ecode == excp_pkg::ADE && wb_esubcode == excp_pkg::ESUBCODE_ADEF)
                      ? wb_pc : wb_vaddr;
        end else if (wr.we && wr.num == csr_addr_pkg::BADV) begin
            badv_q <= merged;
        end
        if (wr.we && wr.num == csr_addr_pkg::EENTRY) begin
            eentry_va_q <= merged[csr_addr_pkg::EENTRY_VA_LO +: csr_addr_pkg::EENTRY_VA_W];
        end
        if (wr.we && save_hit) begin
            save_q[save_idx] <= merged;
        end
    end

    always_comb begin
        is_vec = '0;
        is_vec[excp_pkg::SWI_W-1:0] = swi_q;
        is_vec[excp_pkg::TI_BIT] = timer_int;

        crmd = '0;
        crmd[csr_addr_pkg::CRMD_PLV_LO +: csr_addr_pkg::CRMD_PLV_W] = plv_q;
        crmd[csr_addr_pkg::CRMD_IE_LO] = ie_q;
        crmd[csr_addr_pkg::CRMD_DA_LO] = da_q;
        crmd[csr_addr_pkg::CRMD_PG_LO] = pg_q;

        prmd_word = '0;
        prmd_word[csr_addr_pkg::PRMD_PPLV_LO +: csr_addr_pkg::PRMD_PPLV_W] = pplv_q;
        prmd_word[csr_addr_pkg::PRMD_PIE_LO] = pie_q;

        estat_word = '0;
        estat_word[csr_addr_pkg::ESTAT_IS_LO +: csr_addr_pkg::ESTAT_IS_W] = is_vec;
        estat_word[csr_addr_pkg::ESTAT_ECODE_LO +: csr_addr_pkg::ESTAT_ECODE_W] = ecode_q;
        estat_word[csr_addr_pkg::ESTAT_ESUBCODE_LO +: csr_addr_pkg::ESTAT_ESUBCODE_W] =
            esubcode_q;
    end

    assign ex_entry = {eentry_va_q, {csr_addr_pkg::EENTRY_VA_LO{1'b0}}};
    assign era_pc = era_q;
    assign has_int = (|(is_vec & lie_q)) && ie_q;

    always_comb begin
        case (wr.num)
            csr_addr_pkg::CRMD:   rdata = crmd;
            csr_addr_pkg::PRMD:   rdata = prmd_word;
            csr_addr_pkg::ECFG:   rdata = {{(csr_addr_pkg::DATA_W - excp_pkg::IS_W){1'b0}}, lie_q};
            csr_addr_pkg::ESTAT:  rdata = estat_word;
            csr_addr_pkg::ERA:    rdata = era_q;
            csr_addr_pkg::BADV:   rdata = badv_q;
            csr_addr_pkg::EENTRY: rdata = ex_entry;
            default:              rdata = save_hit ? save_q[save_idx] : '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/csr_write_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_write_if;

    logic                                we;
    csr_addr_pkg::csr_num_e              num;
    logic [csr_addr_pkg::DATA_W-1:0]     wvalue;
    logic [csr_addr_pkg::DATA_W-1:0]     wmask;

    modport producer (output we, output num, output wvalue, output wmask);
    modport consumer (input we, input num, input wvalue, input wmask);

endinterface

`default_nettype wire

//--- design/excp_pkg.sv
`default_nettype none

package excp_pkg;

    localparam int ECODE_W = 6;
    localparam int ESUBCODE_W = 9;

    typedef enum logic [ECODE_W-1:0] {
        INT  = 6'h0,
        PIL  = 6'h1,
        PIS  = 6'h2,
        PIF  = 6'h3,
        PME  = 6'h4,
        PPI  = 6'h7,
        ADE  = 6'h8,
        ALE  = 6'h9,
        SYS  = 6'hB,
        BRK  = 6'hC,
        INE  = 6'hD,
        TLBR = 6'h3F
    } ecode_e;

    // Fetch address error
    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = '0;

    // Interrupt status and enable layout
    localparam int IS_W = 13;
    localparam logic [IS_W-1:0] LIE_MASK = 13'h1BFF;
    localparam int TI_BIT = 11;
    localparam int SWI_W = 2;

endpackage

`default_nettype wire

//--- design/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    localparam int CSR_NUM_W = 14;
    localparam int DATA_W = 32;

    typedef enum logic [CSR_NUM_W-1:0] {
        CRMD   = 14'h0,
        PRMD   = 14'h1,
        ECFG   = 14'h4,
        ESTAT  = 14'h5,
        ERA    = 14'h6,
        BADV   = 14'h7,
        EENTRY = 14'hC,
        SAVE0  = 14'h30,
        SAVE1  = 14'h31,
        SAVE2  = 14'h32,
        SAVE3  = 14'h33,
        TID    = 14'h40,
        TCFG   = 14'h41,
        TVAL   = 14'h42,
        TICLR  = 14'h44
    } csr_num_e;

    // Field positions as low bit and width
    localparam int CRMD_PLV_LO = 0;
    localparam int CRMD_PLV_W = 2;
    localparam int CRMD_IE_LO = 2;
    localparam int CRMD_IE_W = 1;
    localparam int CRMD_DA_LO = 3;
    localparam int CRMD_DA_W = 1;
    localparam int CRMD_PG_LO = 4;
    localparam int CRMD_PG_W = 1;

    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PPLV_W = 2;
    localparam int PRMD_PIE_LO = 2;
    localparam int PRMD_PIE_W = 1;

    localparam int ESTAT_IS_LO = 0;
    localparam int ESTAT_IS_W = 13;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ECODE_W = 6;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int ESTAT_ESUBCODE_W = 9;

    localparam int EENTRY_VA_LO = 6;
    localparam int EENTRY_VA_W = 26;

    localparam int TCFG_EN_LO = 0;
    localparam int TCFG_EN_W = 1;
    localparam int TCFG_PERIODIC_LO = 1;
    localparam int TCFG_PERIODIC_W = 1;
    localparam int TCFG_INITVAL_LO = 2;
    localparam int TCFG_INITVAL_W = 30;

    localparam int TICLR_CLR_LO = 0;
    localparam int TICLR_CLR_W = 1;

endpackage

`default_nettype wire
